// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int OPCODE_W   = 6;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int REG_W      = 5;
    localparam int SHAMT_LSB  = 6;
    localparam int SHAMT_W    = 5;
    localparam int FUNCT_LSB  = 0;
    localparam int FUNCT_W    = 6;
    localparam int IMM_LSB    = 0;
    localparam int IMM_W      = 16;
    localparam int TARGET_LSB = 0;
    localparam int TARGET_W   = 26;

    typedef enum logic [OPCODE_W-1:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function codes under op_special
    typedef enum logic [FUNCT_W-1:0] {
        fn_sll     = 6'h00,
        fn_srl     = 6'h02,
        fn_syscall = 6'h0c,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_xor     = 6'h26,
        fn_slt     = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    // source of the value written back
    typedef enum logic {
        wb_alu,
        wb_memory
    } wb_src_e;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            halted,
    input  logic            redirect,
    input  pipe_pkg::word_t redirect_target,
    output pipe_pkg::word_t pc
);

    pipe_pkg::word_t next_pc;

    // branch or jump resolved in decode wins over the sequential pc
    assign next_pc = redirect ? redirect_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= pipe_pkg::reset_pc;
        end else if (!stall && !halted) begin
            pc <= next_pc;
        end
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::reg_num_t rs_num,
    input  pipe_pkg::reg_num_t rt_num,
    input  logic               wb_en,
    input  pipe_pkg::reg_num_t wb_num,
    input  pipe_pkg::word_t    wb_data,
    output pipe_pkg::word_t    rs_data,
    output pipe_pkg::word_t    rt_data
);

    pipe_pkg::word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_num != 5'd0) begin
            regs[wb_num] <= wb_data;
        end
    end

    // r0 reads zero, same-cycle write is bypassed
    assign rs_data = (rs_num == 5'd0) ? '0 :
                     (wb_en && wb_num == rs_num) ? wb_data : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 :
                     (wb_en && wb_num == rt_num) ? wb_data : regs[rt_num];

    // decode drops writes to r0 before they reach writeback
    no_r0_write: assert property (
        @(posedge clk) disable iff (reset)
        wb_en |-> wb_num != 5'd0
    );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               halted,
    input  pipe_pkg::word_t    pc_in,
    input  pipe_pkg::word_t    inst_in,
    input  pipe_pkg::word_t    ex_result,
    input  pipe_pkg::reg_num_t ex_dest,
    input  logic               ex_reg_write,
    input  logic               ex_is_load,
    input  logic               wb_en,
    input  pipe_pkg::reg_num_t wb_num,
    input  pipe_pkg::word_t    wb_data,
    output logic               stall,
    output logic               redirect,
    output pipe_pkg::word_t    redirect_target,
    output pipe_pkg::word_t    a,
    output pipe_pkg::word_t    b,
    output pipe_pkg::word_t    store_data,
    output pipe_pkg::reg_num_t dest,
    output pipe_pkg::alu_op_e  alu_op,
    output pipe_pkg::wb_src_e  wb_src,
    output logic               reg_write,
    output logic               mem_write,
    output logic               is_halt
);

    pipe_pkg::word_t    id_inst;
    pipe_pkg::word_t    id_pc;
    pipe_pkg::reg_num_t rs;
    pipe_pkg::reg_num_t rt;
    pipe_pkg::reg_num_t rd;
    pipe_pkg::word_t    rs_data;
    pipe_pkg::word_t    rt_data;
    pipe_pkg::word_t    fwd_rs;
    pipe_pkg::word_t    fwd_rt;
    pipe_pkg::word_t    sext_imm;
    pipe_pkg::word_t    zext_imm;
    pipe_pkg::word_t    shamt;
    pipe_pkg::word_t    pc_plus4;
    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    logic               writes;
    logic               taken;
    logic               is_jump;

    // all-zero word decodes as sll r0, which is a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            id_inst <= '0;
        end else if (!stall && !halted) begin
            id_inst <= redirect ? '0 : inst_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !halted) begin
            id_pc <= pc_in;
        end
    end

    assign opcode   = isa_pkg::opcode_e'(id_inst[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W]);
    assign funct    = isa_pkg::funct_e'(id_inst[isa_pkg::FUNCT_LSB +: isa_pkg::FUNCT_W]);
    assign rs       = id_inst[isa_pkg::RS_LSB +: isa_pkg::REG_W];
    assign rt       = id_inst[isa_pkg::RT_LSB +: isa_pkg::REG_W];
    assign rd       = id_inst[isa_pkg::RD_LSB +: isa_pkg::REG_W];
    assign shamt    = {27'd0, id_inst[isa_pkg::SHAMT_LSB +: isa_pkg::SHAMT_W]};
    assign sext_imm = {{16{id_inst[15]}}, id_inst[isa_pkg::IMM_LSB +: isa_pkg::IMM_W]};
    assign zext_imm = {16'd0, id_inst[isa_pkg::IMM_LSB +: isa_pkg::IMM_W]};
    assign pc_plus4 = id_pc + 32'd4;

    register_file regs (
        .clk     (clk),
        .reset   (reset),
        .rs_num  (rs),
        .rt_num  (rt),
        .wb_en   (wb_en),
        .wb_num  (wb_num),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // execute first, result stage comes through the register file bypass
    assign fwd_rs = (ex_reg_write && ex_dest == rs) ? ex_result : rs_data;
    assign fwd_rt = (ex_reg_write && ex_dest == rt) ? ex_result : rt_data;

    assign stall = ex_is_load && (ex_dest == rs || ex_dest == rt);

    always_comb begin
        a         = fwd_rs;
        b         = fwd_rt;
        dest      = rd;
        alu_op    = pipe_pkg::alu_add;
        wb_src    = pipe_pkg::wb_alu;
        writes    = 1'b0;
        mem_write = 1'b0;
        is_halt   = 1'b0;
        taken     = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            isa_pkg::op_special: begin
                writes = 1'b1;
                case (funct)
                    isa_pkg::fn_addu: alu_op = pipe_pkg::alu_add;
                    isa_pkg::fn_subu: alu_op = pipe_pkg::alu_sub;
                    isa_pkg::fn_and:  alu_op = pipe_pkg::alu_and;
                    isa_pkg::fn_or:   alu_op = pipe_pkg::alu_or;
                    isa_pkg::fn_xor:  alu_op = pipe_pkg::alu_xor;
                    isa_pkg::fn_slt:  alu_op = pipe_pkg::alu_slt;
                    isa_pkg::fn_sll: begin
                        a      = shamt;
                        alu_op = pipe_pkg::alu_sll;
                    end
                    isa_pkg::fn_srl: begin
                        a      = shamt;
                        alu_op = pipe_pkg::alu_srl;
                    end
                    isa_pkg::fn_syscall: begin
                        writes  = 1'b0;
                        is_halt = 1'b1;
                    end
                    default: writes = 1'b0;
                endcase
            end
            isa_pkg::op_addiu,
            isa_pkg::op_slti,
            isa_pkg::op_lw: begin
                b      = sext_imm;
                dest   = rt;
                writes = 1'b1;
                if (opcode == isa_pkg::op_slti) begin
                    alu_op = pipe_pkg::alu_slt;
                end
                if (opcode == isa_pkg::op_lw) begin
                    wb_src = pipe_pkg::wb_memory;
                end
            end
            isa_pkg::op_andi,
            isa_pkg::op_ori,
            isa_pkg::op_xori,
            isa_pkg::op_lui: begin
                b      = zext_imm;
                dest   = rt;
                writes = 1'b1;
                case (opcode)
                    isa_pkg::op_andi: alu_op = pipe_pkg::alu_and;
                    isa_pkg::op_ori:  alu_op = pipe_pkg::alu_or;
                    isa_pkg::op_xori: alu_op = pipe_pkg::alu_xor;
                    default:          alu_op = pipe_pkg::alu_lui;
                endcase
            end
            isa_pkg::op_sw: begin
                b         = sext_imm;
                mem_write = 1'b1;
            end
            isa_pkg::op_beq: taken = (fwd_rs == fwd_rt);
            isa_pkg::op_bne: taken = (fwd_rs != fwd_rt);
            isa_pkg::op_j: begin
                taken   = 1'b1;
                is_jump = 1'b1;
            end
            default: ;
        endcase
    end

    assign reg_write  = writes && dest != 5'd0;
    assign store_data = fwd_rt;

    // operands are stale while stalled
    assign redirect = taken && !stall;
    assign redirect_target = is_jump ?
        {pc_plus4[31:28], id_inst[isa_pkg::TARGET_LSB +: isa_pkg::TARGET_W], 2'b00} :
        pc_plus4 + {sext_imm[29:0], 2'b00};

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               halted,
    input  pipe_pkg::word_t    a,
    input  pipe_pkg::word_t    b,
    input  pipe_pkg::word_t    store_data_in,
    input  pipe_pkg::reg_num_t dest_in,
    input  pipe_pkg::alu_op_e  alu_op,
    input  pipe_pkg::wb_src_e  wb_src_in,
    input  logic               reg_write_in,
    input  logic               mem_write_in,
    input  logic               is_halt_in,
    input  logic               bubble,
    output pipe_pkg::word_t    ex_result,
    output pipe_pkg::reg_num_t ex_dest,
    output logic               ex_reg_write,
    output logic               ex_is_load,
    output pipe_pkg::word_t    store_data,
    output pipe_pkg::wb_src_e  wb_src,
    output logic               mem_write,
    output logic               is_halt
);

    pipe_pkg::word_t   a_q;
    pipe_pkg::word_t   b_q;
    pipe_pkg::alu_op_e alu_op_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            mem_write    <= 1'b0;
            is_halt      <= 1'b0;
        end else if (!halted) begin
            ex_reg_write <= reg_write_in && !bubble;
            mem_write    <= mem_write_in && !bubble;
            is_halt      <= is_halt_in && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            a_q        <= a;
            b_q        <= b;
            alu_op_q   <= alu_op;
            ex_dest    <= dest_in;
            store_data <= store_data_in;
            wb_src     <= wb_src_in;
        end
    end

    assign ex_is_load = ex_reg_write && wb_src == pipe_pkg::wb_memory;

    always_comb begin
        case (alu_op_q)
            pipe_pkg::alu_add: ex_result = a_q + b_q;
            pipe_pkg::alu_sub: ex_result = a_q - b_q;
            pipe_pkg::alu_and: ex_result = a_q & b_q;
            pipe_pkg::alu_or:  ex_result = a_q | b_q;
            pipe_pkg::alu_xor: ex_result = a_q ^ b_q;
            pipe_pkg::alu_slt: ex_result = {31'd0, $signed(a_q) < $signed(b_q)};
            pipe_pkg::alu_sll: ex_result = b_q << a_q[4:0];
            pipe_pkg::alu_srl: ex_result = b_q >> a_q[4:0];
            pipe_pkg::alu_lui: ex_result = {b_q[15:0], 16'd0};
            default:           ex_result = '0;
        endcase
    end

    // the bubble clears ex_is_load so a load-use stall lasts one cycle
    one_cycle_stall: assert property (
        @(posedge clk) disable iff (reset)
        (bubble && !halted) |=> !bubble
    );

endmodule

`default_nettype wire

// File: hdl/result_stage.sv
`default_nettype none

module result_stage (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::word_t    store_data,
    input  pipe_pkg::reg_num_t dest,
    input  pipe_pkg::wb_src_e  wb_src,
    input  logic               reg_write,
    input  logic               mem_write,
    input  logic               is_halt,
    input  pipe_pkg::word_t    mem_rdata,
    output pipe_pkg::word_t    mem_addr,
    output pipe_pkg::word_t    mem_wdata,
    output logic               mem_write_en,
    output logic               wb_en,
    output pipe_pkg::reg_num_t wb_num,
    output pipe_pkg::word_t    wb_data,
    output logic               halted
);

    pipe_pkg::wb_src_e wb_src_q;
    logic              reg_write_q;
    logic              mem_write_q;
    logic              is_halt_q;

    // halted is sticky since everything freezes once it is set
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_q <= 1'b0;
            mem_write_q <= 1'b0;
            is_halt_q   <= 1'b0;
            halted      <= 1'b0;
        end else if (!halted) begin
            reg_write_q <= reg_write;
            mem_write_q <= mem_write;
            is_halt_q   <= is_halt;
            halted      <= is_halt_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            mem_addr  <= alu_result;
            mem_wdata <= store_data;
            wb_num    <= dest;
            wb_src_q  <= wb_src;
        end
    end

    assign mem_write_en = mem_write_q && !halted;
    assign wb_en        = reg_write_q && !halted;
    assign wb_data      = (wb_src_q == pipe_pkg::wb_memory) ? mem_rdata : mem_addr;

    // decode never marks a store as writing a register
    store_or_writeback: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_write_en && wb_en)
    );

endmodule

`default_nettype wire

// File: hdl/mips_core.sv
`default_nettype none

module mips_core (
    input  logic            clk,
    input  logic            reset,
    input  pipe_pkg::word_t inst,
    input  pipe_pkg::word_t mem_rdata,
    output pipe_pkg::word_t inst_addr,
    output pipe_pkg::word_t mem_addr,
    output pipe_pkg::word_t mem_wdata,
    output logic            mem_write_en,
    output logic            halted
);

    logic               stall;
    logic               redirect;
    pipe_pkg::word_t    redirect_target;

    // decode to execute
    pipe_pkg::word_t    id_a;
    pipe_pkg::word_t    id_b;
    pipe_pkg::word_t    id_store_data;
    pipe_pkg::reg_num_t id_dest;
    pipe_pkg::alu_op_e  id_alu_op;
    pipe_pkg::wb_src_e  id_wb_src;
    logic               id_reg_write;
    logic               id_mem_write;
    logic               id_is_halt;

    // execute to decode and result
    pipe_pkg::word_t    ex_result;
    pipe_pkg::reg_num_t ex_dest;
    logic               ex_reg_write;
    logic               ex_is_load;
    pipe_pkg::word_t    ex_store_data;
    pipe_pkg::wb_src_e  ex_wb_src;
    logic               ex_mem_write;
    logic               ex_is_halt;

    logic               wb_en;
    pipe_pkg::reg_num_t wb_num;
    pipe_pkg::word_t    wb_data;

    fetch_unit fetch (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .halted          (halted),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (inst_addr)
    );

    decode_stage decode (
        .clk             (clk),
        .reset           (reset),
        .halted          (halted),
        .pc_in           (inst_addr),
        .inst_in         (inst),
        .ex_result       (ex_result),
        .ex_dest         (ex_dest),
        .ex_reg_write    (ex_reg_write),
        .ex_is_load      (ex_is_load),
        .wb_en           (wb_en),
        .wb_num          (wb_num),
        .wb_data         (wb_data),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .a               (id_a),
        .b               (id_b),
        .store_data      (id_store_data),
        .dest            (id_dest),
        .alu_op          (id_alu_op),
        .wb_src          (id_wb_src),
        .reg_write       (id_reg_write),
        .mem_write       (id_mem_write),
        .is_halt         (id_is_halt)
    );

    execute_stage execute (
        .clk           (clk),
        .reset         (reset),
        .halted        (halted),
        .a             (id_a),
        .b             (id_b),
        .store_data_in (id_store_data),
        .dest_in       (id_dest),
        .alu_op        (id_alu_op),
        .wb_src_in     (id_wb_src),
        .reg_write_in  (id_reg_write),
        .mem_write_in  (id_mem_write),
        .is_halt_in    (id_is_halt),
        .bubble        (stall),
        .ex_result     (ex_result),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .ex_is_load    (ex_is_load),
        .store_data    (ex_store_data),
        .wb_src        (ex_wb_src),
        .mem_write     (ex_mem_write),
        .is_halt       (ex_is_halt)
    );

    result_stage result (
        .clk          (clk),
        .reset        (reset),
        .alu_result   (ex_result),
        .store_data   (ex_store_data),
        .dest         (ex_dest),
        .wb_src       (ex_wb_src),
        .reg_write    (ex_reg_write),
        .mem_write    (ex_mem_write),
        .is_halt      (ex_is_halt),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en),
        .wb_en        (wb_en),
        .wb_num       (wb_num),
        .wb_data      (wb_data),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ns;

    // 100 ns period
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: sim/mips_core_tb.sv
`default_nettype none

module mips_core_tb;

    timeunit 1ns;
    timeprecision 1ns;

    logic            clk;
    logic            reset;
    pipe_pkg::word_t inst;
    pipe_pkg::word_t mem_rdata;
    pipe_pkg::word_t inst_addr;
    pipe_pkg::word_t mem_addr;
    pipe_pkg::word_t mem_wdata;
    logic            mem_write_en;
    logic            halted;

    pipe_pkg::word_t rom [256];
    pipe_pkg::word_t ram [256];
    int              prog_len;

    tb_clock clock_gen (.clk(clk));

    mips_core uut (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .mem_rdata    (mem_rdata),
        .inst_addr    (inst_addr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    // single-cycle memories, word indexed by byte address
    assign inst      = rom[inst_addr[9:2]];
    assign mem_rdata = ram[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write_en) begin
            ram[mem_addr[9:2]] <= mem_wdata;
        end
    end

    function automatic pipe_pkg::word_t r_type(isa_pkg::funct_e fn, int rd, int rs, int rt,
                                               int sh);
        pipe_pkg::word_t w;
        w = '0;
        w[isa_pkg::RS_LSB +: isa_pkg::REG_W]       = rs[4:0];
        w[isa_pkg::RT_LSB +: isa_pkg::REG_W]       = rt[4:0];
        w[isa_pkg::RD_LSB +: isa_pkg::REG_W]       = rd[4:0];
        w[isa_pkg::SHAMT_LSB +: isa_pkg::SHAMT_W] = sh[4:0];
        w[isa_pkg::FUNCT_LSB +: isa_pkg::FUNCT_W] = fn;
        return w;
    endfunction

    function automatic pipe_pkg::word_t i_type(isa_pkg::opcode_e op, int rt, int rs, int imm);
        pipe_pkg::word_t w;
        w = '0;
        w[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W] = op;
        w[isa_pkg::RS_LSB +: isa_pkg::REG_W]        = rs[4:0];
        w[isa_pkg::RT_LSB +: isa_pkg::REG_W]        = rt[4:0];
        w[isa_pkg::IMM_LSB +: isa_pkg::IMM_W]       = imm[15:0];
        return w;
    endfunction

    function automatic pipe_pkg::word_t j_type(int word_index);
        pipe_pkg::word_t w;
        w = '0;
        w[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W] = isa_pkg::op_j;
        w[isa_pkg::TARGET_LSB +: isa_pkg::TARGET_W] = word_index[25:0];
        return w;
    endfunction

    // fill varies with every address bit
    function automatic pipe_pkg::word_t fill_value(int i);
        return 32'hc0de_0000 | (i * 32'h0000_0101);
    endfunction

    task automatic emit(input pipe_pkg::word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
            ram[i] = fill_value(i);
        end
        prog_len = 0;
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t got,
                              input pipe_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_until_halt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("core never halted within 2000 cycles");
                $display("** FAIL **");
                $fatal(1, "timeout waiting for halt");
            end
        end
    endtask

    task automatic alu_test();
        pipe_pkg::word_t x;
        pipe_pkg::word_t y;
        pipe_pkg::word_t e [3:10];
        clear_memories();
        x = $urandom();
        y = $urandom();
        ram[0] = x;
        ram[1] = y;
        emit(i_type(isa_pkg::op_lw, 1, 0, 0));
        emit(i_type(isa_pkg::op_lw, 2, 0, 4));
        emit(r_type(isa_pkg::fn_addu, 3, 1, 2, 0));
        emit(r_type(isa_pkg::fn_subu, 4, 1, 3, 0));
        emit(r_type(isa_pkg::fn_and, 5, 4, 1, 0));
        emit(r_type(isa_pkg::fn_or, 6, 5, 2, 0));
        emit(r_type(isa_pkg::fn_xor, 7, 6, 3, 0));
        emit(r_type(isa_pkg::fn_slt, 8, 7, 1, 0));
        emit(r_type(isa_pkg::fn_sll, 9, 0, 7, 5));
        emit(r_type(isa_pkg::fn_srl, 10, 0, 7, 7));
        for (int r = 3; r <= 10; r++) begin
            emit(i_type(isa_pkg::op_sw, r, 0, 32'h40 + 4 * (r - 3)));
        end
        emit(r_type(isa_pkg::fn_syscall, 0, 0, 0, 0));
        reset_core();
        run_until_halt();
        e[3]  = x + y;
        e[4]  = x - e[3];
        e[5]  = e[4] & x;
        e[6]  = e[5] | y;
        e[7]  = e[6] ^ e[3];
        e[8]  = ($signed(e[7]) < $signed(x)) ? 32'd1 : 32'd0;
        e[9]  = e[7] << 5;
        e[10] = e[7] >> 7;
        for (int r = 3; r <= 10; r++) begin
            check_word($sformatf("alu result r%0d", r), ram[16 + r - 3], e[r]);
        end
    endtask

    task automatic immediate_test();
        pipe_pkg::word_t x;
        pipe_pkg::word_t e [2:10];
        clear_memories();
        x = $urandom();
        ram[0] = x;
        emit(i_type(isa_pkg::op_lw, 1, 0, 0));
        emit(i_type(isa_pkg::op_addiu, 2, 1, 16'h8001));
        emit(i_type(isa_pkg::op_addiu, 3, 1, 16'h1234));
        emit(i_type(isa_pkg::op_slti, 4, 1, 16'h8000));
        emit(i_type(isa_pkg::op_slti, 5, 1, 16'h7fff));
        emit(i_type(isa_pkg::op_andi, 6, 1, 16'h8f0f));
        emit(i_type(isa_pkg::op_ori, 7, 1, 16'h8421));
        emit(i_type(isa_pkg::op_xori, 8, 1, 16'hf0f0));
        emit(i_type(isa_pkg::op_lui, 9, 0, 16'h9abc));
        emit(i_type(isa_pkg::op_lui, 10, 0, 16'h1234));
        for (int r = 2; r <= 10; r++) begin
            emit(i_type(isa_pkg::op_sw, r, 0, 32'h80 + 4 * (r - 2)));
        end
        emit(r_type(isa_pkg::fn_syscall, 0, 0, 0, 0));
        reset_core();
        run_until_halt();
        e[2]  = x + 32'hffff_8001;
        e[3]  = x + 32'h0000_1234;
        e[4]  = ($signed(x) < $signed(32'hffff_8000)) ? 32'd1 : 32'd0;
        e[5]  = ($signed(x) < $signed(32'h0000_7fff)) ? 32'd1 : 32'd0;
        e[6]  = x & 32'h0000_8f0f;
        e[7]  = x | 32'h0000_8421;
        e[8]  = x ^ 32'h0000_f0f0;
        e[9]  = 32'h9abc_0000;
        e[10] = 32'h1234_0000;
        for (int r = 2; r <= 10; r++) begin
            check_word($sformatf("immediate result r%0d", r), ram[32 + r - 2], e[r]);
        end
    endtask

    task automatic load_use_test();
        pipe_pkg::word_t x;
        clear_memories();
        x = $urandom();
        ram[0] = x;
        emit(i_type(isa_pkg::op_addiu, 3, 0, 16'h0123));
        emit(i_type(isa_pkg::op_lw, 1, 0, 0));
        emit(r_type(isa_pkg::fn_addu, 2, 1, 3, 0));
        emit(i_type(isa_pkg::op_sw, 2, 0, 16'h40));
        emit(i_type(isa_pkg::op_lw, 4, 0, 0));
        emit(i_type(isa_pkg::op_sw, 4, 0, 16'h44));
        emit(i_type(isa_pkg::op_addiu, 0, 0, 16'h0005));
        emit(i_type(isa_pkg::op_sw, 0, 0, 16'h48));
        emit(r_type(isa_pkg::fn_addu, 0, 1, 1, 0));
        emit(i_type(isa_pkg::op_sw, 0, 0, 16'h4c));
        emit(r_type(isa_pkg::fn_syscall, 0, 0, 0, 0));
        reset_core();
        run_until_halt();
        check_word("load-use sum", ram[16], x + 32'h0000_0123);
        check_word("loaded store data", ram[17], x);
        check_word("r0 after addiu", ram[18], 32'd0);
        check_word("r0 after addu", ram[19], 32'd0);
    endtask

    task automatic branch_test();
        clear_memories();
        emit(i_type(isa_pkg::op_addiu, 1, 0, 5));
        emit(i_type(isa_pkg::op_addiu, 2, 0, 5));
        emit(i_type(isa_pkg::op_addiu, 3, 0, 7));
        emit(i_type(isa_pkg::op_addiu, 9, 0, 1));
        // offsets count words from the instruction after the branch
        emit(i_type(isa_pkg::op_beq, 2, 1, 1));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h40));
        emit(i_type(isa_pkg::op_beq, 3, 1, 1));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h44));
        emit(i_type(isa_pkg::op_bne, 3, 1, 1));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h48));
        emit(i_type(isa_pkg::op_bne, 2, 1, 1));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h4c));
        emit(j_type(14));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h50));
        emit(i_type(isa_pkg::op_sw, 9, 0, 16'h54));
        emit(r_type(isa_pkg::fn_syscall, 0, 0, 0, 0));
        reset_core();
        run_until_halt();
        check_word("after taken beq", ram[16], fill_value(16));
        check_word("after untaken beq", ram[17], 32'd1);
        check_word("after taken bne", ram[18], fill_value(18));
        check_word("after untaken bne", ram[19], 32'd1);
        check_word("after j", ram[20], fill_value(20));
        check_word("j target", ram[21], 32'd1);
    endtask

    task automatic halt_test();
        pipe_pkg::word_t held_pc;
        clear_memories();
        emit(i_type(isa_pkg::op_addiu, 1, 0, 16'h0077));
        emit(i_type(isa_pkg::op_sw, 1, 0, 16'h40));
        emit(r_type(isa_pkg::fn_syscall, 0, 0, 0, 0));
        emit(i_type(isa_pkg::op_sw, 1, 0, 16'h44));
        emit(i_type(isa_pkg::op_sw, 1, 0, 16'h48));
        reset_core();
        run_until_halt();
        // syscall at word 2, fetch runs four words past it until halted rises
        held_pc = 32'd8 + 32'd16;
        repeat (10) begin
            @(negedge clk);
            check_flag("halted", halted, 1'b1);
            check_word("inst_addr", inst_addr, held_pc);
        end
        // stores stuck behind the syscall would have landed by now
        check_word("store before halt", ram[16], 32'h0000_0077);
        check_word("store after halt", ram[17], fill_value(17));
        check_word("second store after halt", ram[18], fill_value(18));
        reset_core();
        @(negedge clk);
        check_flag("halted after reset", halted, 1'b0);
    endtask

    initial begin
        reset = 1'b1;
        prog_len = 0;
        void'($urandom(30));
        alu_test();
        immediate_test();
        load_use_test();
        branch_test();
        halt_test();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/mips_core.sv
sim/tb_clock.sv
sim/mips_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module mips_core_tb -o mips_core_sim

out=$(./obj_dir/mips_core_sim)
echo "$out"

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
else
    exit 1
fi
